//--- flist.f
hw/cpuPkg.sv
hw/regFile.sv
hw/execute.sv
hw/decode.sv
hw/fetch.sv
hw/axiLiteSlave.sv
hw/cpuTop.sv
tb/cpuTb.sv

//--- hw/axiLiteSlave.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave with one outstanding write and one outstanding read
// AW and W must arrive together, a lone address or data beat waits
// Instruction writes need an even address and wstrb[1:0] set
// Program loads are refused while the core is running
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module axiLiteSlave import cpuPkg::*; (
   input  logic                     clk,
   input  logic                     rstN,
   input  logic [AxiAddrWidth-1:0]  awaddr,
   input  logic                     awvalid,
   output logic                     awready,
   input  logic [AxiDataWidth-1:0]  wdata,
   input  logic [3:0]               wstrb,
   input  logic                     wvalid,
   output logic                     wready,
   output logic [1:0]               bresp,
   output logic                     bvalid,
   input  logic                     bready,
   input  logic [AxiAddrWidth-1:0]  araddr,
   input  logic                     arvalid,
   output logic                     arready,
   output logic [AxiDataWidth-1:0]  rdata,
   output logic [1:0]               rresp,
   output logic                     rvalid,
   input  logic                     rready,
   input  logic                     running,
   input  logic                     halted,
   input  logic [DataWidth-1:0]     hostRegData,
   output logic                     imemWe,
   output logic [ImemAddrWidth-1:0] imemAddr,
   output logic [DataWidth-1:0]     imemData,
   output logic                     start,
   output logic [RegAddrWidth-1:0]  hostRegAddr
);
   logic       wrAccept, rdAccept;
   logic       wrImem, wrCtrl, rdCtrl, rdReg;
   logic [1:0] wrResp;

   // Both write channels are taken in the same cycle and only with no B pending
   assign awready  = ~bvalid;
   assign wready   = ~bvalid;
   assign wrAccept = awvalid & wvalid & ~bvalid;

   assign wrImem   = (awaddr <= AddrImemTop) & ~awaddr[0] & (&wstrb[1:0]);
   assign wrCtrl   = (awaddr == AddrCtrl) & wstrb[0];
   assign imemWe   = wrAccept & wrImem & ~running;  // Memory is written at the accept edge
   assign imemAddr = awaddr[ImemAddrWidth:1];       // Byte address to word index
   assign imemData = wdata[DataWidth-1:0];
   assign start    = wrAccept & wrCtrl & wdata[0] & ~running;  // One cycle wide by construction
   assign wrResp   = (imemWe | start) ? RespOkay : RespSlvErr;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         bvalid <= 1'b0;
         bresp  <= RespOkay;
      end else if (wrAccept) begin
         bvalid <= 1'b1;
         bresp  <= wrResp;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   // Read side decodes the status word and the eight registers only
   assign arready     = ~rvalid;
   assign rdAccept    = arvalid & ~rvalid;
   assign rdCtrl      = araddr == AddrCtrl;
   assign rdReg       = (araddr[AxiAddrWidth-1:RegAddrWidth+1] ==
                         AddrRegBase[AxiAddrWidth-1:RegAddrWidth+1]) & ~araddr[0];
   assign hostRegAddr = araddr[RegAddrWidth:1];  // Decode answers in the same cycle

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         rvalid <= 1'b0;
         rresp  <= RespOkay;
      end else if (rdAccept) begin
         rvalid <= 1'b1;
         rresp  <= (rdCtrl | rdReg) ? RespOkay : RespSlvErr;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rdAccept) begin
         if (rdReg) rdata <= AxiDataWidth'(hostRegData);
         else if (rdCtrl) rdata <= AxiDataWidth'({halted, running});  // Bit 1 halted, bit 0 running
         else rdata <= '0;                                            // Unmapped reads return zero
      end
   end

   // A write response must not be withdrawn or changed before the host takes it
   assert property (@(posedge clk) disable iff (!rstN)
      bvalid && !bready |=> bvalid && $stable(bresp));

   // A start pulse puts fetch into the running state on the next edge
   assert property (@(posedge clk) disable iff (!rstN) start |=> running && !halted);

endmodule

//--- hw/cpuPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, opcodes and the AXI4-Lite address map of the core
// Only the listed subset of the 16-bit ISA is decoded
// Any other opcode retires as a no-op
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpuPkg;

   localparam int DataWidth     = 16;                // Architectural word
   localparam int RegAddrWidth  = 3;
   localparam int NumRegs       = 1 << RegAddrWidth;
   localparam int ImemDepth     = 256;               // Instruction words
   localparam int ImemAddrWidth = $clog2(ImemDepth);
   localparam int AxiAddrWidth  = 12;
   localparam int AxiDataWidth  = 32;                // Only the low DataWidth bits carry data

   // Major opcodes sit in instr[15:11]
   localparam logic [4:0] OpHalt  = 5'b00000;
   localparam logic [4:0] OpNop   = 5'b00001;
   localparam logic [4:0] OpJ     = 5'b00100;
   localparam logic [4:0] OpJr    = 5'b00101;
   localparam logic [4:0] OpJal   = 5'b00110;
   localparam logic [4:0] OpAddi  = 5'b01000;
   localparam logic [4:0] OpLbi   = 5'b11000;
   localparam logic [4:0] OpRtype = 5'b11011;

   // Conditional branches share the 011 prefix and test Rs
   localparam logic [4:0] OpBeqz  = 5'b01100;
   localparam logic [4:0] OpBnez  = 5'b01101;
   localparam logic [4:0] OpBltz  = 5'b01110;
   localparam logic [4:0] OpBgez  = 5'b01111;

   // R-type function field in instr[1:0]
   localparam logic [1:0] FnAdd = 2'b00;
   localparam logic [1:0] FnSub = 2'b01;

   localparam logic [RegAddrWidth-1:0] LinkReg = 3'd7;  // JAL return address

   // Byte addresses on the AXI port
   localparam logic [AxiAddrWidth-1:0] AddrImemTop = 12'h1FE;  // Last instruction word
   localparam logic [AxiAddrWidth-1:0] AddrCtrl    = 12'h200;
   localparam logic [AxiAddrWidth-1:0] AddrRegBase = 12'h210;  // R0, then R7 at 0x21E

   localparam logic [1:0] RespOkay   = 2'b00;
   localparam logic [1:0] RespSlvErr = 2'b10;

endpackage

//--- hw/cpuTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-cycle 16-bit core behind one AXI4-Lite slave port
// The host loads the program, starts the core and polls status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cpuTop import cpuPkg::*; (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic [AxiAddrWidth-1:0] awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  logic [AxiDataWidth-1:0] wdata,
   input  logic [3:0]              wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output logic [1:0]              bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  logic [AxiAddrWidth-1:0] araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output logic [AxiDataWidth-1:0] rdata,
   output logic [1:0]              rresp,
   output logic                    rvalid,
   input  logic                    rready
);
   logic                     imemWe, start, running, halted, pcSel, isHalt;
   logic [ImemAddrWidth-1:0] imemAddr;
   logic [RegAddrWidth-1:0]  hostRegAddr;
   logic [DataWidth-1:0]     imemData, hostRegData, instr, pc, target;
   logic [DataWidth-1:0]     reg1Data, reg2Data, aluResult;

   axiLiteSlave i_axiLiteSlave (
      .clk, .rstN, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
      .rvalid, .rready, .running, .halted, .hostRegData, .imemWe, .imemAddr,
      .imemData, .start, .hostRegAddr
   );

   fetch i_fetch (
      .clk, .rstN, .imemWe, .imemAddr, .imemData, .start, .pcSel, .target,
      .isHalt, .instr, .pc, .running, .halted
   );

   decode i_decode (
      .clk, .rstN, .instr, .pc, .aluResult, .running, .hostRegAddr,
      .reg1Data, .reg2Data, .pcSel, .isHalt, .hostRegData
   );

   execute i_execute (.instr, .pc, .reg1Data, .reg2Data, .aluResult, .target);

endmodule

//--- hw/decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode with register file, writeback select and branch resolution
// Writeback happens in the same cycle as the read, one per edge
// JAL forces R7 = PC+2, branches test Rs only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module decode import cpuPkg::*; (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic [DataWidth-1:0]    instr,
   input  logic [DataWidth-1:0]    pc,
   input  logic [DataWidth-1:0]    aluResult,
   input  logic                    running,
   input  logic [RegAddrWidth-1:0] hostRegAddr,
   output logic [DataWidth-1:0]    reg1Data,
   output logic [DataWidth-1:0]    reg2Data,
   output logic                    pcSel,
   output logic                    isHalt,
   output logic [DataWidth-1:0]    hostRegData
);
   logic [4:0]              opcode;
   logic [RegAddrWidth-1:0] rs, rt, rd, writeAddr;
   logic [DataWidth-1:0]    pcPlus2, lbiImm, writeData;
   logic                    isLink, isLbi, writesReg, writeEn;
   logic                    takeBranch, zeroFlag, signFlag;

   assign opcode = instr[15:11];
   assign rs     = instr[10:8];
   assign rt     = instr[7:5];
   assign rd     = instr[4:2];   // R-type destination

   assign lbiImm  = {{(DataWidth-8){instr[7]}}, instr[7:0]};
   assign pcPlus2 = pc + DataWidth'(2);  // Return address for JAL
   assign isHalt  = opcode == OpHalt;
   assign isLink  = opcode == OpJal;
   assign isLbi   = opcode == OpLbi;

   // Destination per format
   always_comb begin
      writesReg = 1'b0;
      writeAddr = rd;
      case (opcode)
         OpAddi:  begin writesReg = 1'b1; writeAddr = rt;      end
         OpRtype: begin writesReg = 1'b1; writeAddr = rd;      end
         OpLbi:   begin writesReg = 1'b1; writeAddr = rs;      end  // LBI loads into Rs
         OpJal:   begin writesReg = 1'b1; writeAddr = LinkReg; end
         OpHalt, OpNop: writesReg = 1'b0;                           // No architectural effect
         default: writesReg = 1'b0;
      endcase
   end

   // Link wins over every other source
   assign writeData = isLink ? pcPlus2 : (isLbi ? lbiImm : aluResult);
   assign writeEn   = running & writesReg;  // Nothing retires while idle or halted

   regFile i_regFile (
      .clk       (clk),
      .rstN      (rstN),
      .readAddr1 (rs),
      .readAddr2 (rt),
      .writeAddr (writeAddr),
      .writeData (writeData),
      .writeEn   (writeEn),
      .hostAddr  (hostRegAddr),
      .readData1 (reg1Data),
      .readData2 (reg2Data),
      .hostData  (hostRegData)
   );

   assign zeroFlag = reg1Data == '0;
   assign signFlag = reg1Data[DataWidth-1];

   always_comb begin
      case (opcode)
         OpBeqz:          takeBranch = zeroFlag;
         OpBnez:          takeBranch = ~zeroFlag;
         OpBltz:          takeBranch = signFlag;
         OpBgez:          takeBranch = ~signFlag;
         OpJ, OpJal, OpJr: takeBranch = 1'b1;  // Unconditional
         default:         takeBranch = 1'b0;
      endcase
   end

   assign pcSel = takeBranch & ~isHalt;  // A HALT never redirects

endmodule

//--- hw/execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational ALU and target adders
// R-type functions other than add and sub yield zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module execute import cpuPkg::*; (
   input  logic [DataWidth-1:0] instr,
   input  logic [DataWidth-1:0] pc,
   input  logic [DataWidth-1:0] reg1Data,
   input  logic [DataWidth-1:0] reg2Data,
   output logic [DataWidth-1:0] aluResult,
   output logic [DataWidth-1:0] target
);
   logic [4:0]           opcode;
   logic [1:0]           fn;
   logic [DataWidth-1:0] imm5Ext, imm8Ext, disp11Ext, pcPlus2;

   assign opcode    = instr[15:11];
   assign fn        = instr[1:0];
   assign imm5Ext   = {{(DataWidth-5){instr[4]}}, instr[4:0]};     // ADDI
   assign imm8Ext   = {{(DataWidth-8){instr[7]}}, instr[7:0]};     // Branch and JR offset
   assign disp11Ext = {{(DataWidth-11){instr[10]}}, instr[10:0]};  // J and JAL
   assign pcPlus2   = pc + DataWidth'(2);

   // Sums wrap at 16 bits
   always_comb begin
      case (opcode)
         OpAddi: aluResult = reg1Data + imm5Ext;
         OpRtype: begin
            case (fn)
               FnAdd:   aluResult = reg1Data + reg2Data;
               FnSub:   aluResult = reg1Data - reg2Data;  // Rs minus Rt
               default: aluResult = '0;
            endcase
         end
         default: aluResult = '0;
      endcase
   end

   // Offsets count halfwords, so each is doubled
   always_comb begin
      case (opcode)
         OpJ, OpJal: target = pcPlus2 + (disp11Ext << 1);
         OpJr:       target = reg1Data + (imm8Ext << 1);  // Register indirect
         default:    target = pcPlus2 + (imm8Ext << 1);   // Conditional branches
      endcase
   end

endmodule

//--- hw/fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction memory and program counter
// The memory reads asynchronously and is only loaded from AXI
// PC bits above the memory index wrap around
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fetch import cpuPkg::*; (
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     imemWe,
   input  logic [ImemAddrWidth-1:0] imemAddr,
   input  logic [DataWidth-1:0]     imemData,
   input  logic                     start,
   input  logic                     pcSel,
   input  logic [DataWidth-1:0]     target,
   input  logic                     isHalt,
   output logic [DataWidth-1:0]     instr,
   output logic [DataWidth-1:0]     pc,
   output logic                     running,
   output logic                     halted
);
   logic [DataWidth-1:0] imem [ImemDepth];
   logic [DataWidth-1:0] pcPlus2;
   logic [DataWidth-1:0] pcNext;

   always_ff @(posedge clk) begin
      if (imemWe) imem[imemAddr] <= imemData;
   end

   assign instr   = imem[pc[ImemAddrWidth:1]];  // Instructions are halfword aligned
   assign pcPlus2 = pc + DataWidth'(2);
   assign pcNext  = pcSel ? target : pcPlus2;   // Taken branch or jump from decode

   // One instruction retires on every edge while running
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc      <= '0;
         running <= 1'b0;
         halted  <= 1'b0;
      end else if (start) begin
         pc      <= '0;     // Every run begins at address zero
         running <= 1'b1;
         halted  <= 1'b0;
      end else if (running) begin
         if (isHalt) begin
            running <= 1'b0;  // PC stays on the HALT
            halted  <= 1'b1;
         end else begin
            pc <= pcNext;
         end
      end
   end

   // Targets from execute, including JR through a register, must stay aligned
   assert property (@(posedge clk) disable iff (!rstN) pc[0] == 1'b0);

endmodule

//--- hw/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight 16-bit registers, all cleared by reset
// Reads are combinational, a read of the written register
// in the same cycle returns the old value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module regFile import cpuPkg::*; (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic [RegAddrWidth-1:0] readAddr1,
   input  logic [RegAddrWidth-1:0] readAddr2,
   input  logic [RegAddrWidth-1:0] writeAddr,
   input  logic [DataWidth-1:0]    writeData,
   input  logic                    writeEn,
   input  logic [RegAddrWidth-1:0] hostAddr,
   output logic [DataWidth-1:0]    readData1,
   output logic [DataWidth-1:0]    readData2,
   output logic [DataWidth-1:0]    hostData
);
   logic [DataWidth-1:0] regs [NumRegs];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeAddr] <= writeData;
      end
   end

   assign readData1 = regs[readAddr1];
   assign readData2 = regs[readAddr2];
   assign hostData  = regs[hostAddr];   // Host read-back port, independent of the core

   // The enable comes from decode and fetch state, an X would corrupt a register
   assert property (@(posedge clk) disable iff (!rstN) !$isunknown(writeEn));

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cpuTb -f flist.f -o cpuSim \
   && ./obj_dir/cpuSim > sim.log 2>&1 \
   || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

//--- tb/cpuTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AXI4-Lite controlled 16-bit core
// Four programs run in turn, registers are never reset in between
// Concurrent assertions do all checking, tasks only feed them
// Stall cycles on bready and rready come from $random, seed 48
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cpuTb import cpuPkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NumPrograms    = 4;
   localparam int WatchdogCycles = NumPrograms * 300 + 2000;

   logic clk = 1'b0;
   logic rstN, awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [AxiAddrWidth-1:0] awaddr, araddr;
   logic [AxiDataWidth-1:0] wdata, rdata;
   logic [3:0]              wstrb;
   logic [1:0]              bresp, rresp;

   integer                  seed = 48;
   int                      checks, valueErrors, protoErrors;
   logic                    chkValid;     // One-cycle strobe into the value assertion
   string                   chkName;
   logic [31:0]             chkGot, chkExp;
   logic [DataWidth-1:0]    prog [$];     // Program image, word 0 at byte address 0
   logic [DataWidth-1:0]    expRegs [NumRegs];

   cpuTop i_cpuTop (.*);

   always #10 clk = ~clk;

   assert property (@(posedge clk) chkValid |-> chkGot == chkExp)
      else begin
         valueErrors++;
         $display("error %s: got %h, expected %h", chkName, chkGot, chkExp);
      end

   // B must follow an accepted write at once and wait for the host
   assert property (@(posedge clk) disable iff (!rstN)
      awvalid && awready && wvalid && wready |=> bvalid)
      else begin
         protoErrors++;
         $display("Write was accepted but no response came in the next cycle");
      end
   assert property (@(posedge clk) disable iff (!rstN)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else begin
         protoErrors++;
         $display("Write response dropped or changed before bready");
      end
   assert property (@(posedge clk) disable iff (!rstN) arvalid && arready |=> rvalid)
      else begin
         protoErrors++;
         $display("Read was accepted but no data came in the next cycle");
      end
   assert property (@(posedge clk) disable iff (!rstN)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else begin
         protoErrors++;
         $display("Read data dropped or changed before rready");
      end

   // AW and W are ready together, and no channel is ready with its response pending
   assert property (@(posedge clk) disable iff (!rstN)
      awready == wready && !(bvalid && awready) && !(rvalid && arready))
      else begin
         protoErrors++;
         $display("Ready signals do not match the pending responses");
      end

   // Called on a falling edge, the assertion samples on the next rising edge
   task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      chkName  = name;
      chkGot   = got;
      chkExp   = exp;
      chkValid = 1'b1;
      @(negedge clk);
      chkValid = 1'b0;
   endtask

   task automatic axiWrite(input logic [AxiAddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                           input logic [1:0] expResp);
      int         stall;
      logic [1:0] resp;
      stall = $unsigned($random(seed)) % 4;
      @(negedge clk);
      awaddr  = addr;
      wdata   = AxiDataWidth'(data);
      awvalid = 1'b1;
      wvalid  = 1'b1;
      while (!(awready && wready)) @(negedge clk);
      @(negedge clk);                     // Taken on the rising edge in between
      awvalid = 1'b0;
      wvalid  = 1'b0;
      while (!bvalid) @(negedge clk);
      repeat (stall) @(negedge clk);      // Response has to survive the stall
      resp   = bresp;
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
      checkValue("bresp", 32'(resp), 32'(expResp));
   endtask

   task automatic axiRead(input logic [AxiAddrWidth-1:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
      int stall;
      stall = $unsigned($random(seed)) % 4;
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      while (!arready) @(negedge clk);
      @(negedge clk);
      arvalid = 1'b0;
      while (!rvalid) @(negedge clk);
      repeat (stall) @(negedge clk);
      data   = rdata;
      resp   = rresp;
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
   endtask

   function automatic logic [15:0] encI(logic [4:0] op, logic [2:0] r, logic [7:0] imm);
      return {op, r, imm};                // LBI, branches and JR
   endfunction

   function automatic logic [15:0] encAddi(logic [2:0] rt, logic [2:0] rs, logic [4:0] imm);
      return {OpAddi, rs, rt, imm};
   endfunction

   function automatic logic [15:0] encR(logic [2:0] rd, logic [2:0] rs, logic [2:0] rt,
                                        logic [1:0] fn);
      return {OpRtype, rs, rt, rd, fn};
   endfunction

   task automatic loadAndStart();
      for (int i = 0; i < prog.size(); i++) begin
         axiWrite(AxiAddrWidth'(2 * i), prog[i], RespOkay);  // Core is idle, so OKAY
      end
      axiWrite(AddrCtrl, 16'h0001, RespOkay);
   endtask

   task automatic waitHalted();
      logic [31:0] status;
      logic [1:0]  resp;
      status = '0;
      while (!status[1]) axiRead(AddrCtrl, status, resp);
      checkValue("status", status, 32'h2);  // Halted set and running clear
      checkValue("rresp", 32'(resp), 32'(RespOkay));
   endtask

   task automatic checkRegs();
      logic [31:0] data;
      logic [1:0]  resp;
      for (int i = 0; i < NumRegs; i++) begin
         axiRead(AddrRegBase + AxiAddrWidth'(2 * i), data, resp);
         checkValue($sformatf("R%0d", i), data, 32'(expRegs[i]));
         checkValue("rresp", 32'(resp), 32'(RespOkay));
      end
   endtask

   task automatic runArith();
      logic [7:0] a, b;
      logic [4:0] c, d;
      a = 8'($random(seed));
      b = 8'($random(seed));
      c = 5'($random(seed));
      d = 5'($random(seed));
      prog.delete();
      prog.push_back(encI(OpLbi, 3'd1, a));
      prog.push_back(encI(OpLbi, 3'd2, b));
      prog.push_back(encAddi(3'd3, 3'd1, c));
      prog.push_back(encAddi(3'd4, 3'd2, d));
      prog.push_back(encR(3'd5, 3'd3, 3'd4, FnAdd));
      prog.push_back(encR(3'd6, 3'd3, 3'd4, FnSub));
      prog.push_back(encR(3'd0, 3'd4, 3'd3, FnSub));  // Reverse order for the other sign
      prog.push_back({OpHalt, 11'd0});
      expRegs[1] = {{8{a[7]}}, a};
      expRegs[2] = {{8{b[7]}}, b};
      expRegs[3] = expRegs[1] + {{11{c[4]}}, c};      // 16-bit sums wrap by width
      expRegs[4] = expRegs[2] + {{11{d[4]}}, d};
      expRegs[5] = expRegs[3] + expRegs[4];
      expRegs[6] = expRegs[3] - expRegs[4];
      expRegs[0] = expRegs[4] - expRegs[3];
      loadAndStart();
      waitHalted();
      checkRegs();
   endtask

   // Each register gets a test value, a branch on it, then a marker that a taken branch skips
   task automatic runBranches();
      logic [4:0]  ops [8];
      logic [7:0]  vals [8];
      logic [15:0] v;
      logic        taken;
      ops  = '{OpBeqz, OpBeqz, OpBnez, OpBnez, OpBltz, OpBltz, OpBgez, OpBgez};
      vals = '{8'h00, 8'h05, 8'h00, 8'hFD, 8'hFD, 8'h05, 8'h00, 8'hFD};
      prog.delete();
      for (int i = 0; i < 8; i++) begin
         prog.push_back(encI(OpLbi, 3'(i), vals[i]));
         prog.push_back(encI(ops[i], 3'(i), 8'h01));        // Target is PC+4
         prog.push_back(encI(OpLbi, 3'(i), 8'(8'h40 + i)));
         v = {{8{vals[i][7]}}, vals[i]};
         case (ops[i])
            OpBeqz:  taken = v == '0;
            OpBnez:  taken = v != '0;
            OpBltz:  taken = v[15];
            default: taken = !v[15];                         // BGEZ
         endcase
         expRegs[i] = taken ? v : 16'(8'h40 + i);
      end
      prog.push_back({OpHalt, 11'd0});
      loadAndStart();
      waitHalted();
      checkRegs();
   endtask

   task automatic runCalls();
      prog.delete();
      prog.push_back(encI(OpLbi, 3'd1, 8'h11));   // 0x0
      prog.push_back({OpJal, 11'd3});             // 0x2 calls 0xA
      prog.push_back(encI(OpLbi, 3'd2, 8'h22));   // 0x4 runs after the return
      prog.push_back({OpHalt, 11'd0});            // 0x6
      prog.push_back(encI(OpLbi, 3'd3, 8'h7F));   // 0x8 jumped over
      prog.push_back(encI(OpLbi, 3'd4, 8'h44));   // 0xA subroutine
      prog.push_back(encI(OpJr, 3'd7, 8'h00));    // 0xC back through R7
      expRegs[1] = 16'h0011;
      expRegs[2] = 16'h0022;
      expRegs[4] = 16'h0044;
      expRegs[7] = 16'h0002 + 16'h0002;           // JAL address plus 2
      loadAndStart();
      waitHalted();
      checkRegs();
   endtask

   // A countdown of about 200 cycles keeps the core busy for the refused writes
   task automatic runErrors();
      logic [31:0] data;
      logic [1:0]  resp;
      prog.delete();
      prog.push_back(encI(OpLbi, 3'd1, 8'd100));
      prog.push_back(encAddi(3'd1, 3'd1, 5'h1F));
      prog.push_back(encI(OpBnez, 3'd1, 8'hFE));  // Back to the ADDI
      prog.push_back({OpHalt, 11'd0});
      expRegs[1] = 16'h0000;
      loadAndStart();
      axiWrite(12'h000, 16'hFFFF, RespSlvErr);    // Memory is locked while running
      axiWrite(AddrCtrl, 16'h0001, RespSlvErr);   // Second start
      waitHalted();
      axiRead(12'h300, data, resp);               // Unmapped
      checkValue("rdata", data, 32'h0);
      checkValue("rresp", 32'(resp), 32'(RespSlvErr));
      axiRead(12'h000, data, resp);               // Instruction memory is write only
      checkValue("rdata", data, 32'h0);
      checkValue("rresp", 32'(resp), 32'(RespSlvErr));
      checkRegs();
   endtask

   task automatic printCounts();
      $display("Checks %0d, value errors %0d, protocol errors %0d",
               checks, valueErrors, protoErrors);
   endtask

   initial begin
      rstN    = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = 4'hF;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      chkValid = 1'b0;
      checks = 0;
      valueErrors = 0;
      protoErrors = 0;
      foreach (expRegs[i]) expRegs[i] = '0;
      repeat (10) @(negedge clk);
      rstN = 1'b1;
      runArith();
      runBranches();
      runCalls();
      runErrors();
      printCounts();
      if (valueErrors == 0 && protoErrors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WatchdogCycles) @(posedge clk);
      $display("Timeout after %0d cycles, the programs did not all finish", WatchdogCycles);
      printCounts();
      $display("Test FAILED");
      $finish;
   end

endmodule
